//--- ccu.f
common/ccu_pkg.sv
common/ccu_biu_if.sv
ccu_arb/ccu_arb.sv
biu/biu.sv
src/ccu.sv
verification/tb_clock.sv
verification/tb_bus_mem.sv
verification/ccu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the CCU testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module ccu_tb \
    -f ccu.f \
    --Mdir obj_dir \
    -o ccu_sim

./obj_dir/ccu_sim > sim.log 2>&1
cat sim.log

if grep -q "^Test OK$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

//--- verification/ccu_tb.sv
/* CCU testbench */

`timescale 1ns/1ps
`default_nettype none

module ccu_tb
    import ccu_pkg::*;
();

    localparam int NPORT          = OPTN_CCU_ARB_DEPTH;
    localparam int WORD_BYTES     = OPTN_DATA_WIDTH / 8;
    localparam int RANDOM_REQS    = 200;
    localparam int REREQ_REQS     = 20;
    localparam int REQ_COUNT      = 1 + 2 + 2 + RANDOM_REQS + REREQ_REQS;
    localparam int TIMEOUT_CYCLES = 40 * REQ_COUNT + 200;

    logic                         clk;
    logic                         n_rst;
    logic [NPORT-1:0]             req_valid;
    logic [NPORT-1:0]             req_we;
    logic [OPTN_ADDR_WIDTH-1:0]   req_addr  [0:NPORT-1];
    logic [LINE_WIDTH-1:0]        req_wline [0:NPORT-1];
    logic [NPORT-1:0]             req_done;
    logic [LINE_WIDTH-1:0]        req_rline;
    logic                         bus_req;
    logic                         bus_we;
    logic [OPTN_ADDR_WIDTH-1:0]   bus_addr;
    logic [OPTN_DATA_WIDTH-1:0]   bus_wdata;
    logic                         bus_ack;
    logic [OPTN_DATA_WIDTH-1:0]   bus_rdata;

    // Reference line memory and bookkeeping
    logic [LINE_WIDTH-1:0]        model_mem [logic [OPTN_ADDR_WIDTH-1:0]];
    int                           exp_done_port [$];
    logic [OPTN_ADDR_WIDTH-1:0]   bus_addr_q [$];
    logic                         bus_we_q [$];
    logic [OPTN_DATA_WIDTH-1:0]   bus_wdata_q [$];
    logic                         bus_req_prev = 1'b0;
    integer                       seed = 32'h79e6;
    int                           err_count = 0;
    int                           pass_tests = 0;
    int                           fail_tests = 0;
    int                           bus_word_total = 0;
    int                           cycle_count = 0;

    tb_clock #(.PERIOD_NS(20), .RST_CYCLES(2)) u_clock (
        .o_clk   (clk),
        .o_n_rst (n_rst)
    );

    ccu UUT (
        .clk         (clk),
        .n_rst       (n_rst),
        .i_req_valid (req_valid),
        .i_req_we    (req_we),
        .i_req_addr  (req_addr),
        .i_req_wline (req_wline),
        .o_req_done  (req_done),
        .o_req_rline (req_rline),
        .o_bus_req   (bus_req),
        .o_bus_we    (bus_we),
        .o_bus_addr  (bus_addr),
        .o_bus_wdata (bus_wdata),
        .i_bus_ack   (bus_ack),
        .i_bus_rdata (bus_rdata)
    );

    tb_bus_mem #(
        .ADDR_W (OPTN_ADDR_WIDTH),
        .DATA_W (OPTN_DATA_WIDTH),
        .SEED   (32'h79e6)
    ) u_mem (
        .clk         (clk),
        .n_rst       (n_rst),
        .i_bus_req   (bus_req),
        .i_bus_we    (bus_we),
        .i_bus_addr  (bus_addr),
        .i_bus_wdata (bus_wdata),
        .o_bus_ack   (bus_ack),
        .o_bus_rdata (bus_rdata)
    );

    // Unwritten words read as address XOR 5a5a0000
    function automatic logic [LINE_WIDTH-1:0] initial_line(input logic [OPTN_ADDR_WIDTH-1:0] addr);
        logic [LINE_WIDTH-1:0]      line;
        logic [OPTN_ADDR_WIDTH-1:0] waddr;
        line = '0;
        for (int i = 0; i < LINE_WORDS; i++) begin
            waddr = addr + OPTN_ADDR_WIDTH'(i * WORD_BYTES);
            line[i*OPTN_DATA_WIDTH +: OPTN_DATA_WIDTH] =
                OPTN_DATA_WIDTH'(waddr) ^ OPTN_DATA_WIDTH'(32'h5a5a_0000);
        end
        return line;
    endfunction

    function automatic logic [LINE_WIDTH-1:0] expected_line(input logic [OPTN_ADDR_WIDTH-1:0] addr);
        if (model_mem.exists(addr)) begin
            return model_mem[addr];
        end
        return initial_line(addr);
    endfunction

    function automatic logic [LINE_WIDTH-1:0] random_line();
        logic [LINE_WIDTH-1:0] line;
        for (int i = 0; i < LINE_WORDS; i++) begin
            line[i*OPTN_DATA_WIDTH +: OPTN_DATA_WIDTH] = OPTN_DATA_WIDTH'($random(seed));
        end
        return line;
    endfunction

    function automatic int port_of(input logic [NPORT-1:0] vec);
        for (int i = 0; i < NPORT; i++) begin
            if (vec[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic check_line(input logic [LINE_WIDTH-1:0] got, input logic [LINE_WIDTH-1:0] exp,
                              input logic [OPTN_ADDR_WIDTH-1:0] addr);
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] %0t ns: read line %h got %h expected %h", $time, addr, got, exp);
        end
    endtask

    task automatic check_done(input int got, input int exp);
        if (got != exp) begin
            err_count++;
            $display("[FAIL] %0t ns: done pulse on port %0d, expected port %0d", $time, got, exp);
        end
    endtask

    task automatic check_bus_word(input logic [OPTN_ADDR_WIDTH-1:0] got_addr,
                                  input logic [OPTN_ADDR_WIDTH-1:0] exp_addr,
                                  input logic got_we, input logic exp_we,
                                  input logic [OPTN_DATA_WIDTH-1:0] got_wdata,
                                  input logic [OPTN_DATA_WIDTH-1:0] exp_wdata);
        if (got_addr !== exp_addr || got_we !== exp_we ||
            (exp_we && got_wdata !== exp_wdata)) begin
            err_count++;
            $display("[FAIL] %0t ns: bus word addr %h we %b data %h, %s %h we %b data %h",
                     $time, got_addr, got_we, got_wdata, "expected addr",
                     exp_addr, exp_we, exp_wdata);
        end
    endtask

    // Done pulses are matched to requests in grant order
    always @(negedge clk) begin
        if (n_rst && req_done != '0) begin
            if (!$onehot(req_done)) begin
                err_count++;
                $display("Error at %0t ns: more than one port saw done at once", $time);
            end else if (exp_done_port.size() == 0) begin
                err_count++;
                $display("Error at %0t ns: done pulse with no request pending", $time);
            end else begin
                check_done(port_of(req_done), exp_done_port.pop_front());
            end
        end
    end

    // Each rising req is one bus word
    always @(negedge clk) begin
        if (n_rst) begin
            if (bus_req && !bus_req_prev) begin
                bus_addr_q.push_back(bus_addr);
                bus_we_q.push_back(bus_we);
                bus_wdata_q.push_back(bus_wdata);
                bus_word_total++;
            end
            bus_req_prev = bus_req;
        end
    end

    // Holds one client request until its done, then checks it
    task automatic serve_client(input int p, input logic we, input logic [OPTN_ADDR_WIDTH-1:0] addr,
                                input logic [LINE_WIDTH-1:0] wline);
        int nwords;
        @(negedge clk);
        req_valid[p] = 1'b1;
        req_we[p]    = we;
        req_addr[p]  = addr;
        req_wline[p] = wline;
        do begin
            @(negedge clk);
        end while (!req_done[p]);
        if (we) begin
            model_mem[addr] = wline;
        end else begin
            check_line(req_rline, expected_line(addr), addr);
        end
        nwords = bus_addr_q.size();
        if (nwords != LINE_WORDS) begin
            err_count++;
            $display("Error at %0t ns: port %0d request moved %0d bus words instead of %0d",
                     $time, p, nwords, LINE_WORDS);
            bus_addr_q.delete();
            bus_we_q.delete();
            bus_wdata_q.delete();
        end else begin
            for (int i = 0; i < LINE_WORDS; i++) begin
                check_bus_word(bus_addr_q.pop_front(), addr + OPTN_ADDR_WIDTH'(i * WORD_BYTES),
                               bus_we_q.pop_front(), we,
                               bus_wdata_q.pop_front(),
                               wline[i*OPTN_DATA_WIDTH +: OPTN_DATA_WIDTH]);
            end
        end
        req_valid[p] = 1'b0;
    endtask

    task automatic do_request(input int p, input logic we, input logic [OPTN_ADDR_WIDTH-1:0] addr,
                              input logic [LINE_WIDTH-1:0] wline);
        exp_done_port.push_back(p);
        serve_client(p, we, addr, wline);
    endtask

    task automatic finish_test(input int num, input string name, input int errs_before);
        if (err_count == errs_before) begin
            pass_tests++;
            $display("test %0d %s: pass", num, name);
        end else begin
            fail_tests++;
            $display("test %0d %s: fail, %0d errors", num, name, err_count - errs_before);
        end
    endtask

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: simulation stopped after %0d cycles without finishing", cycle_count);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        int                         errs;
        int                         words_before;
        int                         port;
        logic                       we;
        logic [OPTN_ADDR_WIDTH-1:0] addr;
        logic [LINE_WIDTH-1:0]      line;

        req_valid = '0;
        req_we    = '0;
        for (int i = 0; i < NPORT; i++) begin
            req_addr[i]  = '0;
            req_wline[i] = '0;
        end
        wait (n_rst);
        @(negedge clk);

        errs = err_count;
        do_request(0, 1'b0, 32'h0000_1000, '0);
        finish_test(1, "single read on port 0", errs);

        errs = err_count;
        line = random_line();
        do_request(1, 1'b1, 32'h0000_2000, line);
        do_request(0, 1'b0, 32'h0000_2000, '0);
        finish_test(2, "write port 1 then read port 0", errs);

        // Port 0 writes the line that port 1 then reads
        errs = err_count;
        line = random_line();
        exp_done_port.push_back(0);
        exp_done_port.push_back(1);
        fork
            serve_client(0, 1'b1, 32'h0000_3000, line);
            serve_client(1, 1'b0, 32'h0000_3000, '0);
        join
        finish_test(3, "simultaneous requests", errs);

        errs = err_count;
        for (int n = 0; n < RANDOM_REQS; n++) begin
            port = {$random(seed)} % NPORT;
            we   = 1'($random(seed));
            addr = 32'h0000_4000 + OPTN_ADDR_WIDTH'(({$random(seed)} % 8) * OPTN_DC_LINE_SIZE);
            do_request(port, we, addr, random_line());
        end
        finish_test(4, "random requests", errs);

        // Back-to-back on one client
        errs         = err_count;
        words_before = bus_word_total;
        for (int n = 0; n < REREQ_REQS; n++) begin
            we   = 1'($random(seed));
            addr = 32'h0000_4000 + OPTN_ADDR_WIDTH'(({$random(seed)} % 8) * OPTN_DC_LINE_SIZE);
            do_request(1, we, addr, random_line());
        end
        repeat (4) @(negedge clk);
        if (bus_word_total - words_before != LINE_WORDS * REREQ_REQS) begin
            err_count++;
            $display("Error at %0t ns: %0d bus words for %0d requests", $time,
                     bus_word_total - words_before, REREQ_REQS);
        end
        finish_test(5, "re-request after done", errs);

        if (exp_done_port.size() != 0 || bus_word_total != LINE_WORDS * REQ_COUNT) begin
            err_count++;
            $display("Error: %0d requests never completed, %0d bus words in total",
                     exp_done_port.size(), bus_word_total);
        end
        $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
                 pass_tests, fail_tests, err_count);
        if (fail_tests == 0 && err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/tb_bus_mem.sv
/* Four-phase bus memory model */

`timescale 1ns/1ps
`default_nettype none

module tb_bus_mem #(
    parameter int ADDR_W = 32,
    parameter int DATA_W = 32,
    parameter int SEED   = 32'h79e6
)(
    input  wire logic              clk,
    input  wire logic              n_rst,
    input  wire logic              i_bus_req,
    input  wire logic              i_bus_we,
    input  wire logic [ADDR_W-1:0] i_bus_addr,
    input  wire logic [DATA_W-1:0] i_bus_wdata,
    output logic                   o_bus_ack,
    output logic      [DATA_W-1:0] o_bus_rdata
);

    // Sparse storage keyed by byte address
    logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];
    integer            seed;
    int                delay;

    function automatic logic [DATA_W-1:0] read_word(input logic [ADDR_W-1:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return DATA_W'(addr) ^ DATA_W'(32'h5a5a_0000);
    endfunction

    // Ack and its release each lag by 0 to 3 cycles
    initial begin
        seed        = SEED;
        o_bus_ack   = 1'b0;
        o_bus_rdata = '0;
        forever begin
            @(negedge clk);
            if (n_rst && i_bus_req && !o_bus_ack) begin
                delay = {$random(seed)} % 4;
                repeat (delay) @(negedge clk);
                if (i_bus_we) begin
                    mem[i_bus_addr] = i_bus_wdata;
                end else begin
                    o_bus_rdata = read_word(i_bus_addr);
                end
                o_bus_ack = 1'b1;
                while (i_bus_req) @(negedge clk);
                delay = {$random(seed)} % 4;
                repeat (delay) @(negedge clk);
                o_bus_ack = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_clock.sv
/* Testbench clock and reset */

`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 2
)(
    output logic o_clk,
    output logic o_n_rst
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // Release away from the rising edge
    initial begin
        o_n_rst = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_n_rst = 1'b1;
    end

endmodule

`default_nettype wire

//--- src/ccu.sv
/* Core communications unit */

`timescale 1ns/1ps
`default_nettype none

module ccu
    import ccu_pkg::*;
#(
    parameter int OPTN_DATA_WIDTH    = ccu_pkg::OPTN_DATA_WIDTH,
    parameter int OPTN_ADDR_WIDTH    = ccu_pkg::OPTN_ADDR_WIDTH,
    parameter int OPTN_DC_LINE_SIZE  = ccu_pkg::OPTN_DC_LINE_SIZE,
    parameter int OPTN_CCU_ARB_DEPTH = ccu_pkg::OPTN_CCU_ARB_DEPTH
)(
    input  wire logic                          clk,
    input  wire logic                          n_rst,

    // Cache clients, port 0 data cache, port 1 fetch
    input  wire logic [OPTN_CCU_ARB_DEPTH-1:0]  i_req_valid,
    input  wire logic [OPTN_CCU_ARB_DEPTH-1:0]  i_req_we,
    input  wire logic [OPTN_ADDR_WIDTH-1:0]     i_req_addr  [0:OPTN_CCU_ARB_DEPTH-1],
    input  wire logic [OPTN_DC_LINE_SIZE*8-1:0] i_req_wline [0:OPTN_CCU_ARB_DEPTH-1],
    output logic      [OPTN_CCU_ARB_DEPTH-1:0]  o_req_done,
    output logic      [OPTN_DC_LINE_SIZE*8-1:0] o_req_rline,

    // External memory bus
    output logic                                o_bus_req,
    output logic                                o_bus_we,
    output logic      [OPTN_ADDR_WIDTH-1:0]     o_bus_addr,
    output logic      [OPTN_DATA_WIDTH-1:0]     o_bus_wdata,
    input  wire logic                           i_bus_ack,
    input  wire logic [OPTN_DATA_WIDTH-1:0]     i_bus_rdata
);

    ccu_biu_if #(
        .ADDR_W (OPTN_ADDR_WIDTH),
        .LINE_W (OPTN_DC_LINE_SIZE * 8)
    ) ccu_link ();

    ccu_arb #(
        .OPTN_ADDR_WIDTH    (OPTN_ADDR_WIDTH),
        .OPTN_CCU_ARB_DEPTH (OPTN_CCU_ARB_DEPTH),
        .OPTN_DC_LINE_SIZE  (OPTN_DC_LINE_SIZE)
    ) u_ccu_arb (
        .clk             (clk),
        .n_rst           (n_rst),
        .i_ccu_arb_valid (i_req_valid),
        .i_ccu_arb_we    (i_req_we),
        .i_ccu_arb_addr  (i_req_addr),
        .i_ccu_arb_data  (i_req_wline),
        .o_ccu_arb_done  (o_req_done),
        .o_ccu_arb_data  (o_req_rline),
        .biu             (ccu_link.arb)
    );

    biu #(
        .OPTN_DATA_WIDTH   (OPTN_DATA_WIDTH),
        .OPTN_ADDR_WIDTH   (OPTN_ADDR_WIDTH),
        .OPTN_DC_LINE_SIZE (OPTN_DC_LINE_SIZE)
    ) u_biu (
        .clk         (clk),
        .n_rst       (n_rst),
        .ccu         (ccu_link.biu),
        .o_bus_req   (o_bus_req),
        .o_bus_we    (o_bus_we),
        .o_bus_addr  (o_bus_addr),
        .o_bus_wdata (o_bus_wdata),
        .i_bus_ack   (i_bus_ack),
        .i_bus_rdata (i_bus_rdata)
    );

endmodule

`default_nettype wire

//--- biu/biu.sv
/* Bus interface unit */

`timescale 1ns/1ps
`default_nettype none

module biu
    import ccu_pkg::*;
#(
    parameter int OPTN_DATA_WIDTH   = 32,
    parameter int OPTN_ADDR_WIDTH   = 32,
    parameter int OPTN_DC_LINE_SIZE = 16
)(
    input  wire logic                       clk,
    input  wire logic                       n_rst,

    ccu_biu_if.biu ccu,

    // External four-phase bus
    output logic                            o_bus_req,
    output logic                            o_bus_we,
    output logic      [OPTN_ADDR_WIDTH-1:0] o_bus_addr,
    output logic      [OPTN_DATA_WIDTH-1:0] o_bus_wdata,
    input  wire logic                       i_bus_ack,
    input  wire logic [OPTN_DATA_WIDTH-1:0] i_bus_rdata
);

    localparam int LINE_W     = OPTN_DC_LINE_SIZE * 8;
    localparam int WORDS      = LINE_W / OPTN_DATA_WIDTH;
    localparam int WORD_BYTES = OPTN_DATA_WIDTH / 8;
    localparam int WORD_IDX_W = (WORDS > 1) ? $clog2(WORDS) : 1;
    localparam int LINE_OFS_W = $clog2(OPTN_DC_LINE_SIZE);

    biu_state_e                 state;
    biu_state_e                 state_next;
    logic [WORD_IDX_W-1:0]      word_idx;
    logic                       last_word;
    logic                       we_q;
    logic [OPTN_ADDR_WIDTH-1:0] addr_q;
    logic [LINE_W-1:0]          wline_q;
    logic [LINE_W-1:0]          rline_q;

    assign last_word = (word_idx == WORD_IDX_W'(WORDS - 1));

    always_comb begin
        state_next = state;
        case (state)
            BIU_IDLE: begin
                if (ccu.en) begin
                    state_next = BIU_REQ;
                end
            end
            BIU_REQ: begin
                if (i_bus_ack) begin
                    state_next = BIU_ACK_LOW;
                end
            end
            BIU_ACK_LOW: begin
                // Memory must release ack before the next word
                if (!i_bus_ack) begin
                    state_next = last_word ? BIU_DONE : BIU_REQ;
                end
            end
            BIU_DONE:    state_next = BIU_RELEASE;
            BIU_RELEASE: begin
                if (!ccu.en) begin
                    state_next = BIU_IDLE;
                end
            end
            default:     state_next = BIU_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state <= BIU_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            word_idx <= '0;
        end else if (state == BIU_IDLE) begin
            word_idx <= '0;
        end else if (state == BIU_ACK_LOW && !i_bus_ack && !last_word) begin
            word_idx <= word_idx + 1'b1;
        end
    end

    // Line request latch
    always_ff @(posedge clk) begin
        if (state == BIU_IDLE && ccu.en) begin
            we_q    <= ccu.we;
            addr_q  <= ccu.addr;
            wline_q <= ccu.wline;
        end
    end

    // Gather read words into the line
    always_ff @(posedge clk) begin
        if (state == BIU_REQ && i_bus_ack && !we_q) begin
            rline_q[word_idx*OPTN_DATA_WIDTH +: OPTN_DATA_WIDTH] <= i_bus_rdata;
        end
    end

    assign o_bus_req   = (state == BIU_REQ);
    assign o_bus_we    = we_q;
    assign o_bus_addr  = addr_q + OPTN_ADDR_WIDTH'(word_idx * WORD_BYTES);
    assign o_bus_wdata = wline_q[word_idx*OPTN_DATA_WIDTH +: OPTN_DATA_WIDTH];

    assign ccu.busy  = (state == BIU_REQ) || (state == BIU_ACK_LOW);
    assign ccu.done  = (state == BIU_DONE);
    assign ccu.rline = rline_q;

    // Req holds until the memory answers
    a_req_held: assert property (@(posedge clk) disable iff (!n_rst)
        (o_bus_req && !i_bus_ack) |=> o_bus_req);

    a_bus_stable: assert property (@(posedge clk) disable iff (!n_rst)
        (o_bus_req && $past(o_bus_req)) |-> ($stable(o_bus_addr) && $stable(o_bus_wdata)));

    // Clients only ever ask for whole lines
    a_line_aligned: assert property (@(posedge clk) disable iff (!n_rst)
        (state != BIU_IDLE) |-> (addr_q[LINE_OFS_W-1:0] == '0));

endmodule

`default_nettype wire

//--- ccu_arb/ccu_arb.sv
/* CCU fixed-priority arbiter */

`timescale 1ns/1ps
`default_nettype none

module ccu_arb
    import ccu_pkg::*;
#(
    parameter int OPTN_ADDR_WIDTH    = 32,
    parameter int OPTN_CCU_ARB_DEPTH = 2,
    parameter int OPTN_DC_LINE_SIZE  = 16
)(
    input  wire logic                       clk,
    input  wire logic                       n_rst,

    // Client requests
    input  wire logic [OPTN_CCU_ARB_DEPTH-1:0] i_ccu_arb_valid,
    input  wire logic [OPTN_CCU_ARB_DEPTH-1:0] i_ccu_arb_we,
    input  wire logic [OPTN_ADDR_WIDTH-1:0]    i_ccu_arb_addr [0:OPTN_CCU_ARB_DEPTH-1],
    input  wire logic [OPTN_DC_LINE_SIZE*8-1:0] i_ccu_arb_data [0:OPTN_CCU_ARB_DEPTH-1],
    output logic      [OPTN_CCU_ARB_DEPTH-1:0] o_ccu_arb_done,
    output logic      [OPTN_DC_LINE_SIZE*8-1:0] o_ccu_arb_data,

    ccu_biu_if.arb biu
);

    localparam int IDX_W = (OPTN_CCU_ARB_DEPTH > 1) ? $clog2(OPTN_CCU_ARB_DEPTH) : 1;

    arb_state_e                    state;
    arb_state_e                    state_next;
    logic [OPTN_CCU_ARB_DEPTH-1:0] eligible;
    logic                          any_valid;
    logic [IDX_W-1:0]              grant_idx;
    logic [IDX_W-1:0]              idx_q;

    // Client that just got done still shows valid for a cycle
    assign eligible  = i_ccu_arb_valid & ~o_ccu_arb_done;
    assign any_valid = |eligible;

    // Lowest index wins
    always_comb begin
        grant_idx = '0;
        for (int i = OPTN_CCU_ARB_DEPTH - 1; i >= 0; i--) begin
            if (eligible[i]) begin
                grant_idx = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            idx_q <= '0;
        end else if (state == ARB_IDLE) begin
            idx_q <= grant_idx;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ARB_IDLE: begin
                if (any_valid) begin
                    state_next = ARB_BUSY;
                end
            end
            ARB_BUSY: begin
                if (biu.done) begin
                    state_next = ARB_DONE;
                end
            end
            ARB_DONE: state_next = ARB_IDLE;
            default:  state_next = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state <= ARB_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Request towards the BIU
    always_ff @(posedge clk) begin
        biu.we    <= i_ccu_arb_we[idx_q];
        biu.addr  <= i_ccu_arb_addr[idx_q];
        biu.wline <= i_ccu_arb_data[idx_q];
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            biu.en <= 1'b0;
        end else begin
            biu.en <= (state == ARB_BUSY) && i_ccu_arb_valid[idx_q];
        end
    end

    // Completion back to the granted client only
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_ccu_arb_done <= '0;
        end else begin
            for (int i = 0; i < OPTN_CCU_ARB_DEPTH; i++) begin
                o_ccu_arb_done[i] <= (state == ARB_DONE) && (idx_q == IDX_W'(i));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (biu.done) begin
            o_ccu_arb_data <= biu.rline;
        end
    end

    a_done_onehot: assert property (@(posedge clk) disable iff (!n_rst)
        $onehot0(o_ccu_arb_done));

    a_idle_no_en: assert property (@(posedge clk) disable iff (!n_rst)
        (state == ARB_IDLE) |-> !biu.en);

    // No line may still be moving once the arbiter is free to grant
    a_idle_not_busy: assert property (@(posedge clk) disable iff (!n_rst)
        (state == ARB_IDLE) |-> !biu.busy);

endmodule

`default_nettype wire

//--- common/ccu_biu_if.sv
/* Arbiter to BIU line request link */

`timescale 1ns/1ps
`default_nettype none

interface ccu_biu_if
    import ccu_pkg::*;
#(
    parameter int ADDR_W = OPTN_ADDR_WIDTH,
    parameter int LINE_W = LINE_WIDTH
)();

    // Request side, held by the arbiter
    logic              en;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [LINE_W-1:0] wline;

    // Completion side
    logic              done;
    logic              busy;
    logic [LINE_W-1:0] rline;

    modport arb (
        output en,
        output we,
        output addr,
        output wline,
        input  done,
        input  busy,
        input  rline
    );

    modport biu (
        input  en,
        input  we,
        input  addr,
        input  wline,
        output done,
        output busy,
        output rline
    );

endinterface

`default_nettype wire

//--- common/ccu_pkg.sv
/* CCU shared definitions */

`default_nettype none

package ccu_pkg;

    // Bus word width, overridable from the top level
    parameter int OPTN_DATA_WIDTH    = 32;

    // Byte address width
    parameter int OPTN_ADDR_WIDTH    = 32;

    // Cache line size in bytes
    parameter int OPTN_DC_LINE_SIZE  = 16;

    // Number of cache clients on the arbiter
    parameter int OPTN_CCU_ARB_DEPTH = 2;

    // Line geometry
    parameter int LINE_WIDTH = OPTN_DC_LINE_SIZE * 8;
    parameter int LINE_WORDS = LINE_WIDTH / OPTN_DATA_WIDTH;

    // Arbiter FSM
    typedef enum logic [1:0] {
        ARB_IDLE = 2'b00,
        ARB_BUSY = 2'b01,
        ARB_DONE = 2'b10
    } arb_state_e;

    // BIU FSM, one four-phase cycle per word
    typedef enum logic [2:0] {
        BIU_IDLE    = 3'b000,
        BIU_REQ     = 3'b001,
        BIU_ACK_LOW = 3'b010,
        BIU_DONE    = 3'b011,
        BIU_RELEASE = 3'b100
    } biu_state_e;

endpackage

`default_nettype wire
